/* verilog/core_cfg_pkg.sv */
package core_cfg_pkg;

    // datapath and pc width.
    localparam int XLEN = 32;

    // physical register tags.
    localparam int PREG_W   = 6;
    localparam int PREG_NUM = 1 << PREG_W;

    // reorder buffer numbering.
    localparam int ROB_W   = 6;
    localparam int ROB_NUM = 1 << ROB_W;

endpackage

/* verilog/isa_pkg.sv */
package isa_pkg;

    // field widths of the mips-style word.
    localparam int OPCODE_W = 6;
    localparam int REG_W    = 5;
    localparam int SHAMT_W  = 5;
    localparam int FUNCT_W  = 6;
    localparam int IMM_W    = 16;

    // major opcodes.
    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'd0;
    localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'd8;
    localparam logic [OPCODE_W-1:0] OP_SLTI  = 6'd10;
    localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'd12;
    localparam logic [OPCODE_W-1:0] OP_ORI   = 6'd13;
    localparam logic [OPCODE_W-1:0] OP_XORI  = 6'd14;
    localparam logic [OPCODE_W-1:0] OP_LUI   = 6'd15;

    // funct codes under OP_RTYPE.
    localparam logic [FUNCT_W-1:0] FN_SLL = 6'd0;
    localparam logic [FUNCT_W-1:0] FN_SRL = 6'd2;
    localparam logic [FUNCT_W-1:0] FN_ADD = 6'd32;
    localparam logic [FUNCT_W-1:0] FN_SUB = 6'd34;
    localparam logic [FUNCT_W-1:0] FN_AND = 6'd36;
    localparam logic [FUNCT_W-1:0] FN_OR  = 6'd37;
    localparam logic [FUNCT_W-1:0] FN_XOR = 6'd38;
    localparam logic [FUNCT_W-1:0] FN_SLT = 6'd42;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_LUI = 4'd8
    } alu_op_t;

    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        logic [REG_W-1:0]    rs;
        logic [REG_W-1:0]    rt;
        logic [REG_W-1:0]    rd;
        logic [SHAMT_W-1:0]  shamt;
        logic [FUNCT_W-1:0]  funct;
    } r_fmt_t;

    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        logic [REG_W-1:0]    rs;
        logic [REG_W-1:0]    rt;
        logic [IMM_W-1:0]    imm16;
    } i_fmt_t;

    // same 32 bits, read as either format.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

/* verilog/issue_decode.sv */
`timescale 1ns/1ps

module issue_decode #(
    parameter int ISSUE_WIDTH = 3
) (
    input  logic                                                   clk,
    input  logic                                                   rstn,
    input  logic [ISSUE_WIDTH-1:0]                                 issue_valid,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]         issue_pc,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]         issue_instr,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]         issue_src_a,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]         issue_src_b,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0]       issue_dest,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::ROB_W-1:0]        issue_rob,
    output logic [ISSUE_WIDTH-1:0]                                 dec_valid,
    output logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]         dec_pc,
    output isa_pkg::alu_op_t [ISSUE_WIDTH-1:0]                     dec_op,
    output logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]         dec_a,
    output logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]         dec_b,
    output logic [ISSUE_WIDTH-1:0][isa_pkg::SHAMT_W-1:0]           dec_shamt,
    output logic [ISSUE_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0]       dec_dest,
    output logic [ISSUE_WIDTH-1:0][core_cfg_pkg::ROB_W-1:0]        dec_rob,
    output logic [ISSUE_WIDTH-1:0]                                 illegal
);

    localparam int XLEN  = core_cfg_pkg::XLEN;
    localparam int IMM_W = isa_pkg::IMM_W;

    logic [ISSUE_WIDTH-1:0]                           valid_q;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]                 pc_q;
    isa_pkg::instr_u [ISSUE_WIDTH-1:0]                instr_q;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]                 src_a_q;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]                 src_b_q;
    logic [ISSUE_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0] dest_q;
    logic [ISSUE_WIDTH-1:0][core_cfg_pkg::ROB_W-1:0]  rob_q;

    // issue register, edge N.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
            pc_q    <= '0;
            instr_q <= '0;
            src_a_q <= '0;
            src_b_q <= '0;
            dest_q  <= '0;
            rob_q   <= '0;
        end else begin
            valid_q <= issue_valid;
            pc_q    <= issue_pc;
            instr_q <= issue_instr;
            src_a_q <= issue_src_a;
            src_b_q <= issue_src_b;
            dest_q  <= issue_dest;
            rob_q   <= issue_rob;
        end
    end

    assign dec_pc   = pc_q;
    assign dec_a    = src_a_q;
    assign dec_dest = dest_q;
    assign dec_rob  = rob_q;

    for (genvar s = 0; s < ISSUE_WIDTH; s++) begin : g_slot
        isa_pkg::instr_u              word;
        isa_pkg::alu_op_t             op;
        logic [XLEN-1:0]              b_val;
        logic [isa_pkg::SHAMT_W-1:0]  shamt;
        logic [XLEN-1:0]              sext_imm;
        logic [XLEN-1:0]              zext_imm;
        logic                         legal;

        assign word     = instr_q[s];
        assign sext_imm = {{(XLEN-IMM_W){word.i.imm16[IMM_W-1]}}, word.i.imm16};
        assign zext_imm = {{(XLEN-IMM_W){1'b0}}, word.i.imm16};

        always_comb begin
            op    = isa_pkg::ALU_ADD;
            b_val = zext_imm;
            shamt = '0;
            legal = 1'b1;
            case (word.r.opcode)
                isa_pkg::OP_RTYPE: begin
                    b_val = src_b_q[s];
                    shamt = word.r.shamt;
                    case (word.r.funct)
                        isa_pkg::FN_ADD: op = isa_pkg::ALU_ADD;
                        isa_pkg::FN_SUB: op = isa_pkg::ALU_SUB;
                        isa_pkg::FN_AND: op = isa_pkg::ALU_AND;
                        isa_pkg::FN_OR:  op = isa_pkg::ALU_OR;
                        isa_pkg::FN_XOR: op = isa_pkg::ALU_XOR;
                        isa_pkg::FN_SLT: op = isa_pkg::ALU_SLT;
                        isa_pkg::FN_SLL: op = isa_pkg::ALU_SLL;
                        isa_pkg::FN_SRL: op = isa_pkg::ALU_SRL;
                        default:         legal = 1'b0;
                    endcase
                end
                isa_pkg::OP_ADDI: begin
                    op    = isa_pkg::ALU_ADD;
                    b_val = sext_imm;
                end
                isa_pkg::OP_SLTI: begin
                    op    = isa_pkg::ALU_SLT;
                    b_val = sext_imm;
                end
                isa_pkg::OP_ANDI: op = isa_pkg::ALU_AND;
                isa_pkg::OP_ORI:  op = isa_pkg::ALU_OR;
                isa_pkg::OP_XORI: op = isa_pkg::ALU_XOR;
                // lane moves the low half up.
                isa_pkg::OP_LUI:  op = isa_pkg::ALU_LUI;
                default:          legal = 1'b0;
            endcase
        end

        assign dec_op[s]    = op;
        assign dec_b[s]     = b_val;
        assign dec_shamt[s] = shamt;
        assign dec_valid[s] = valid_q[s] & legal;
        assign illegal[s]   = valid_q[s] & ~legal;
    end

endmodule

/* verilog/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              dec_valid,
    input  logic [core_cfg_pkg::XLEN-1:0]     dec_pc,
    input  isa_pkg::alu_op_t                  dec_op,
    input  logic [core_cfg_pkg::XLEN-1:0]     dec_a,
    input  logic [core_cfg_pkg::XLEN-1:0]     dec_b,
    input  logic [isa_pkg::SHAMT_W-1:0]       dec_shamt,
    input  logic [core_cfg_pkg::PREG_W-1:0]   dec_dest,
    input  logic [core_cfg_pkg::ROB_W-1:0]    dec_rob,
    output logic                              ex_valid,
    output logic [core_cfg_pkg::XLEN-1:0]     ex_pc,
    output logic [core_cfg_pkg::XLEN-1:0]     ex_result,
    output logic [core_cfg_pkg::PREG_W-1:0]   ex_dest,
    output logic [core_cfg_pkg::ROB_W-1:0]    ex_rob
);

    localparam int XLEN  = core_cfg_pkg::XLEN;
    localparam int IMM_W = isa_pkg::IMM_W;

    logic [XLEN-1:0] alu_out;
    logic            lt_signed;

    assign lt_signed = $signed(dec_a) < $signed(dec_b);

    always_comb begin
        case (dec_op)
            isa_pkg::ALU_ADD: alu_out = dec_a + dec_b;
            isa_pkg::ALU_SUB: alu_out = dec_a - dec_b;
            isa_pkg::ALU_AND: alu_out = dec_a & dec_b;
            isa_pkg::ALU_OR:  alu_out = dec_a | dec_b;
            isa_pkg::ALU_XOR: alu_out = dec_a ^ dec_b;
            isa_pkg::ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, lt_signed};
            // shifts work on the rt operand.
            isa_pkg::ALU_SLL: alu_out = dec_b << dec_shamt;
            isa_pkg::ALU_SRL: alu_out = dec_b >> dec_shamt;
            isa_pkg::ALU_LUI: alu_out = {dec_b[IMM_W-1:0], {(XLEN-IMM_W){1'b0}}};
            default:          alu_out = '0;
        endcase
    end

    // ex/mem register, edge N+1.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_valid  <= 1'b0;
            ex_pc     <= '0;
            ex_result <= '0;
            ex_dest   <= '0;
            ex_rob    <= '0;
        end else begin
            ex_valid  <= dec_valid;
            ex_pc     <= dec_pc;
            ex_result <= alu_out;
            ex_dest   <= dec_dest;
            ex_rob    <= dec_rob;
        end
    end

endmodule

/* verilog/writeback_commit.sv */
`timescale 1ns/1ps

module writeback_commit #(
    parameter int ISSUE_WIDTH = 3
) (
    input  logic                                               clk,
    input  logic                                               rstn,
    input  logic [ISSUE_WIDTH-1:0]                             ex_valid,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]     ex_result,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0]   ex_dest,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::ROB_W-1:0]    ex_rob,
    input  logic                                               retire_valid,
    input  logic [core_cfg_pkg::ROB_W-1:0]                     retire_rob,
    input  logic [core_cfg_pkg::PREG_W-1:0]                    rd_preg,
    output logic [core_cfg_pkg::ROB_NUM-1:0]                   rob_done,
    output logic [core_cfg_pkg::XLEN-1:0]                      rd_data
);

    logic [core_cfg_pkg::XLEN-1:0] prf [core_cfg_pkg::PREG_NUM];

    // lanes are visited in order, so the highest lane wins a shared dest.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < core_cfg_pkg::PREG_NUM; r++) begin
                prf[r] <= '0;
            end
        end else begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (ex_valid[l]) begin
                    prf[ex_dest[l]] <= ex_result[l];
                end
            end
        end
    end

    // retire clears first, a completing lane sets after it.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rob_done <= '0;
        end else begin
            if (retire_valid) begin
                rob_done[retire_rob] <= 1'b0;
            end
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (ex_valid[l]) begin
                    rob_done[ex_rob[l]] <= 1'b1;
                end
            end
        end
    end

    assign rd_data = prf[rd_preg];

endmodule

/* verilog/exec_cluster_top.sv */
`timescale 1ns/1ps

module exec_cluster_top #(
    parameter int ISSUE_WIDTH = 3
) (
    input  logic                                               clk,
    input  logic                                               rstn,
    input  logic [ISSUE_WIDTH-1:0]                             issue_valid,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]     issue_pc,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]     issue_instr,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]     issue_src_a,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]     issue_src_b,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0]   issue_dest,
    input  logic [ISSUE_WIDTH-1:0][core_cfg_pkg::ROB_W-1:0]    issue_rob,
    input  logic                                               retire_valid,
    input  logic [core_cfg_pkg::ROB_W-1:0]                     retire_rob,
    input  logic [core_cfg_pkg::PREG_W-1:0]                    rd_preg,
    output logic [ISSUE_WIDTH-1:0]                             ex_valid,
    output logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]     ex_pc,
    output logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]     ex_result,
    output logic [ISSUE_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0]   ex_dest,
    output logic [ISSUE_WIDTH-1:0][core_cfg_pkg::ROB_W-1:0]    ex_rob,
    output logic [ISSUE_WIDTH-1:0]                             illegal,
    output logic [core_cfg_pkg::ROB_NUM-1:0]                   rob_done,
    output logic [core_cfg_pkg::XLEN-1:0]                      rd_data
);

    logic [ISSUE_WIDTH-1:0]                             dec_valid;
    logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]     dec_pc;
    isa_pkg::alu_op_t [ISSUE_WIDTH-1:0]                 dec_op;
    logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]     dec_a;
    logic [ISSUE_WIDTH-1:0][core_cfg_pkg::XLEN-1:0]     dec_b;
    logic [ISSUE_WIDTH-1:0][isa_pkg::SHAMT_W-1:0]       dec_shamt;
    logic [ISSUE_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0]   dec_dest;
    logic [ISSUE_WIDTH-1:0][core_cfg_pkg::ROB_W-1:0]    dec_rob;

    issue_decode #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) i_decode (
        .clk         (clk),
        .rstn        (rstn),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_instr (issue_instr),
        .issue_src_a (issue_src_a),
        .issue_src_b (issue_src_b),
        .issue_dest  (issue_dest),
        .issue_rob   (issue_rob),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_op      (dec_op),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .dec_shamt   (dec_shamt),
        .dec_dest    (dec_dest),
        .dec_rob     (dec_rob),
        .illegal     (illegal)
    );

    // one alu lane per issue slot.
    for (genvar g = 0; g < ISSUE_WIDTH; g++) begin : g_lane
        exec_lane i_lane (
            .clk       (clk),
            .rstn      (rstn),
            .dec_valid (dec_valid[g]),
            .dec_pc    (dec_pc[g]),
            .dec_op    (dec_op[g]),
            .dec_a     (dec_a[g]),
            .dec_b     (dec_b[g]),
            .dec_shamt (dec_shamt[g]),
            .dec_dest  (dec_dest[g]),
            .dec_rob   (dec_rob[g]),
            .ex_valid  (ex_valid[g]),
            .ex_pc     (ex_pc[g]),
            .ex_result (ex_result[g]),
            .ex_dest   (ex_dest[g]),
            .ex_rob    (ex_rob[g])
        );
    end

    writeback_commit #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) i_writeback (
        .clk          (clk),
        .rstn         (rstn),
        .ex_valid     (ex_valid),
        .ex_result    (ex_result),
        .ex_dest      (ex_dest),
        .ex_rob       (ex_rob),
        .retire_valid (retire_valid),
        .retire_rob   (retire_rob),
        .rd_preg      (rd_preg),
        .rob_done     (rob_done),
        .rd_data      (rd_data)
    );

endmodule

/* sim/exec_cluster_sva.sv */
`timescale 1ns/1ps

module exec_cluster_sva #(
    parameter int ISSUE_WIDTH = 3
) (
    input logic                                             clk,
    input logic                                             rstn,
    input logic [ISSUE_WIDTH-1:0]                           ex_valid,
    input logic [ISSUE_WIDTH-1:0][core_cfg_pkg::ROB_W-1:0]  ex_rob,
    input logic [core_cfg_pkg::ROB_NUM-1:0]                 rob_done
);

    // rob numbers carried by a valid lane this cycle.
    logic [core_cfg_pkg::ROB_NUM-1:0] lane_hit;

    always_comb begin
        lane_hit = '0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (ex_valid[l]) begin
                lane_hit[ex_rob[l]] = 1'b1;
            end
        end
    end

    for (genvar r = 0; r < core_cfg_pkg::ROB_NUM; r++) begin : g_rob
        a_done_has_lane: assert property (
            @(posedge clk) disable iff (!rstn) $rose(rob_done[r]) |-> $past(lane_hit[r])
        ) else $error("rob_done[%0d] rose with no lane completing that rob", r);
    end

    // first edge out of reset leaves every done bit clear.
    a_reset_clears_done: assert property (@(posedge clk) $rose(rstn) |=> rob_done == '0)
        else $error("rob_done not zero after reset release");

endmodule

bind writeback_commit exec_cluster_sva #(.ISSUE_WIDTH(ISSUE_WIDTH)) i_sva (
    .clk      (clk),
    .rstn     (rstn),
    .ex_valid (ex_valid),
    .ex_rob   (ex_rob),
    .rob_done (rob_done)
);

/* sim/exec_cluster_tb.sv */
`timescale 1ns/1ps

module exec_cluster_tb;

    localparam int W          = 3;
    localparam int XLEN       = core_cfg_pkg::XLEN;
    localparam int NROWS      = 12;
    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 16;

    logic                                         clk;
    logic                                         rstn;
    logic [W-1:0]                                 issue_valid;
    logic [W-1:0][XLEN-1:0]                       issue_pc;
    logic [W-1:0][XLEN-1:0]                       issue_instr;
    logic [W-1:0][XLEN-1:0]                       issue_src_a;
    logic [W-1:0][XLEN-1:0]                       issue_src_b;
    logic [W-1:0][core_cfg_pkg::PREG_W-1:0]       issue_dest;
    logic [W-1:0][core_cfg_pkg::ROB_W-1:0]        issue_rob;
    logic                                         retire_valid;
    logic [core_cfg_pkg::ROB_W-1:0]               retire_rob;
    logic [core_cfg_pkg::PREG_W-1:0]              rd_preg;
    logic [W-1:0]                                 ex_valid;
    logic [W-1:0][XLEN-1:0]                       ex_pc;
    logic [W-1:0][XLEN-1:0]                       ex_result;
    logic [W-1:0][core_cfg_pkg::PREG_W-1:0]       ex_dest;
    logic [W-1:0][core_cfg_pkg::ROB_W-1:0]        ex_rob;
    logic [W-1:0]                                 illegal;
    logic [core_cfg_pkg::ROB_NUM-1:0]             rob_done;
    logic [XLEN-1:0]                              rd_data;

    // stimulus table, one row per issue cycle.
    logic [W-1:0]     row_valid   [NROWS];
    logic [W-1:0]     row_ill     [NROWS];
    logic [XLEN-1:0]  row_instr   [NROWS][W];
    logic [XLEN-1:0]  row_a       [NROWS][W];
    logic [XLEN-1:0]  row_b       [NROWS][W];
    logic [XLEN-1:0]  row_exp     [NROWS][W];
    logic [5:0]       row_dest    [NROWS][W];
    logic [5:0]       row_rob     [NROWS][W];
    logic             row_ret_v   [NROWS];
    logic [5:0]       row_ret_rob [NROWS];
    string            row_name    [NROWS];
    int               row_err     [NROWS];

    logic [XLEN-1:0]                  shadow_prf [core_cfg_pkg::PREG_NUM];
    logic [core_cfg_pkg::ROB_NUM-1:0] shadow_done;
    int                               err_count;
    int                               check_count;

    exec_cluster_top #(.ISSUE_WIDTH(W)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        @(posedge rstn);
        #((NROWS + 20) * CLK_PERIOD);
        $display("watchdog expired before the last row was checked");
        $display("Done: errors found");
        $finish;
    end

    function automatic logic [XLEN-1:0] r_word(input logic [5:0] funct, input logic [4:0] shamt);
        return {6'd0, 5'd1, 5'd2, 5'd3, shamt, funct};
    endfunction

    function automatic logic [XLEN-1:0] i_word(input logic [5:0] opcode, input logic [15:0] imm);
        return {opcode, 5'd1, 5'd2, imm};
    endfunction

    function automatic logic [XLEN-1:0] slot_pc(input int r, input int s);
        return 32'h0000_1000 + 32'(r * W + s) * 4;
    endfunction

    // reference alu, straight from the isa rules.
    function automatic logic [XLEN-1:0] ref_result(input logic [XLEN-1:0] word,
                                                    input logic [XLEN-1:0] a,
                                                    input logic [XLEN-1:0] b);
        logic [15:0]     imm;
        logic [XLEN-1:0] sx;
        logic [XLEN-1:0] zx;
        logic [XLEN-1:0] res;
        imm = word[15:0];
        sx  = {{16{imm[15]}}, imm};
        zx  = {16'h0000, imm};
        res = '0;
        case (word[31:26])
            6'd0: begin
                case (word[5:0])
                    6'd32:   res = a + b;
                    6'd34:   res = a - b;
                    6'd36:   res = a & b;
                    6'd37:   res = a | b;
                    6'd38:   res = a ^ b;
                    6'd42:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'd0:    res = b << word[10:6];
                    6'd2:    res = b >> word[10:6];
                    default: res = '0;
                endcase
            end
            6'd8:    res = a + sx;
            6'd10:   res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            6'd12:   res = a & zx;
            6'd13:   res = a | zx;
            6'd14:   res = a ^ zx;
            6'd15:   res = {imm, 16'h0000};
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic set_slot(input int r, input int s, input logic [XLEN-1:0] word,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                            input logic ill);
        row_valid[r][s] = 1'b1;
        row_ill[r][s]   = ill;
        row_instr[r][s] = word;
        row_a[r][s]     = a;
        row_b[r][s]     = b;
        row_exp[r][s]   = ref_result(word, a, b);
        row_dest[r][s]  = 6'(r * W + s + 1);
        row_rob[r][s]   = 6'(r * W + s);
    endtask

    task automatic build_table();
        for (int r = 0; r < NROWS; r++) begin
            row_valid[r]   = '0;
            row_ill[r]     = '0;
            row_ret_v[r]   = 1'b0;
            row_ret_rob[r] = '0;
            row_name[r]    = "idle";
            row_err[r]     = 0;
            for (int s = 0; s < W; s++) begin
                row_instr[r][s] = '0;
                row_a[r][s]     = '0;
                row_b[r][s]     = '0;
                row_exp[r][s]   = '0;
                row_dest[r][s]  = '0;
                row_rob[r][s]   = '0;
            end
        end
        row_name[0] = "r-type add sub and";
        set_slot(0, 0, r_word(6'd32, 5'd0), $urandom(), $urandom(), 1'b0);
        set_slot(0, 1, r_word(6'd34, 5'd0), $urandom(), $urandom(), 1'b0);
        set_slot(0, 2, r_word(6'd36, 5'd0), $urandom(), $urandom(), 1'b0);
        row_name[1] = "r-type or xor slt";
        set_slot(1, 0, r_word(6'd37, 5'd0), $urandom(), $urandom(), 1'b0);
        set_slot(1, 1, r_word(6'd38, 5'd0), $urandom(), $urandom(), 1'b0);
        set_slot(1, 2, r_word(6'd42, 5'd0), $urandom(), $urandom(), 1'b0);
        row_name[2] = "shifts and signed slt";
        set_slot(2, 0, r_word(6'd0, 5'd5), $urandom(), $urandom(), 1'b0);
        set_slot(2, 1, r_word(6'd2, 5'd17), $urandom(), $urandom(), 1'b0);
        set_slot(2, 2, r_word(6'd42, 5'd0), 32'hffff_fff0, 32'd5, 1'b0);
        row_name[3] = "addi slti andi";
        set_slot(3, 0, i_word(6'd8, 16'hfff0), $urandom(), 32'd0, 1'b0);
        set_slot(3, 1, i_word(6'd10, 16'h8000), 32'd5, 32'd0, 1'b0);
        set_slot(3, 2, i_word(6'd12, 16'hf0f0), $urandom(), 32'd0, 1'b0);
        row_name[4] = "ori xori lui";
        set_slot(4, 0, i_word(6'd13, 16'h8001), $urandom(), 32'd0, 1'b0);
        set_slot(4, 1, i_word(6'd14, 16'hffff), $urandom(), 32'd0, 1'b0);
        set_slot(4, 2, i_word(6'd15, 16'hbeef), $urandom(), 32'd0, 1'b0);
        row_name[5] = "illegal opcode and funct";
        set_slot(5, 0, i_word(6'd63, 16'h1234), $urandom(), 32'd0, 1'b1);
        set_slot(5, 1, r_word(6'd32, 5'd0), $urandom(), $urandom(), 1'b0);
        set_slot(5, 2, r_word(6'd1, 5'd0), $urandom(), $urandom(), 1'b1);
        row_name[6] = "shared destination";
        set_slot(6, 0, r_word(6'd32, 5'd0), $urandom(), $urandom(), 1'b0);
        set_slot(6, 1, r_word(6'd34, 5'd0), $urandom(), $urandom(), 1'b0);
        set_slot(6, 2, r_word(6'd38, 5'd0), $urandom(), $urandom(), 1'b0);
        row_dest[6][0] = 6'd40;
        row_dest[6][2] = 6'd40;
        row_name[7]    = "retire clear";
        row_ret_v[7]   = 1'b1;
        row_ret_rob[7] = 6'd0;
        // rob 20 completes again on the same edge as its retire in row 10.
        row_name[8] = "reissue rob 20";
        set_slot(8, 0, i_word(6'd8, 16'h0042), $urandom(), 32'd0, 1'b0);
        row_rob[8][0] = 6'd20;
        row_name[9]   = "mixed random";
        set_slot(9, 0, r_word(6'd34, 5'd0), $urandom(), $urandom(), 1'b0);
        set_slot(9, 1, r_word(6'd37, 5'd0), $urandom(), $urandom(), 1'b0);
        set_slot(9, 2, r_word(6'd42, 5'd0), $urandom(), $urandom(), 1'b0);
        row_name[10] = "retire against set";
        for (int s = 0; s < W; s++) begin
            set_slot(10, s, r_word(6'd32, 5'd0), $urandom(), $urandom(), 1'b0);
        end
        row_ret_v[10]   = 1'b1;
        row_ret_rob[10] = 6'd20;
        row_name[11]    = "retire old rob";
        set_slot(11, 1, i_word(6'd14, 16'h00ff), $urandom(), 32'd0, 1'b0);
        row_ret_v[11]   = 1'b1;
        row_ret_rob[11] = 6'd4;
    endtask

    task automatic drive_row(input int r);
        for (int s = 0; s < W; s++) begin
            if (r < NROWS) begin
                issue_valid[s] = row_valid[r][s];
                issue_pc[s]    = slot_pc(r, s);
                issue_instr[s] = row_instr[r][s];
                issue_src_a[s] = row_a[r][s];
                issue_src_b[s] = row_b[r][s];
                issue_dest[s]  = row_dest[r][s];
                issue_rob[s]   = row_rob[r][s];
            end else begin
                issue_valid[s] = 1'b0;
            end
        end
        retire_valid = (r < NROWS) ? row_ret_v[r] : 1'b0;
        retire_rob   = (r < NROWS) ? row_ret_rob[r] : '0;
    endtask

    task automatic fail_check(input int row, input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        err_count++;
        if (row >= 0 && row < NROWS) begin
            row_err[row]++;
        end
    endtask

    // edge t clears the retire of row t-1, then sets row t-3.
    task automatic update_shadow(input int t);
        int r;
        r = t - 1;
        if (r >= 0 && r < NROWS && row_ret_v[r]) begin
            shadow_done[row_ret_rob[r]] = 1'b0;
        end
        r = t - 3;
        if (r >= 0 && r < NROWS) begin
            for (int s = 0; s < W; s++) begin
                if (row_valid[r][s] && !row_ill[r][s]) begin
                    shadow_prf[row_dest[r][s]] = row_exp[r][s];
                    shadow_done[row_rob[r][s]] = 1'b1;
                end
            end
        end
    endtask

    task automatic check_outputs(input int t);
        int           r;
        logic [W-1:0] exp_ill;
        logic         exp_v;
        r       = t - 1;
        exp_ill = (r >= 0 && r < NROWS) ? (row_ill[r] & row_valid[r]) : '0;
        check_count++;
        if (illegal !== exp_ill) begin
            fail_check(r, $sformatf("row %0d illegal %b, expected %b", r, illegal, exp_ill));
        end
        r = t - 2;
        for (int s = 0; s < W; s++) begin
            exp_v = (r >= 0 && r < NROWS) ? (row_valid[r][s] & ~row_ill[r][s]) : 1'b0;
            check_count++;
            if (ex_valid[s] !== exp_v) begin
                fail_check(r, $sformatf("row %0d lane %0d ex_valid %b", r, s, ex_valid[s]));
            end else if (exp_v) begin
                if (ex_result[s] !== row_exp[r][s]) begin
                    fail_check(r, $sformatf("row %0d lane %0d result %h, expected %h",
                                            r, s, ex_result[s], row_exp[r][s]));
                end
                if (ex_pc[s] !== slot_pc(r, s) || ex_dest[s] !== row_dest[r][s] ||
                    ex_rob[s] !== row_rob[r][s]) begin
                    fail_check(r, $sformatf("row %0d lane %0d pc, dest or rob wrong", r, s));
                end
            end
        end
        r = t - 3;
        check_count++;
        if (rob_done !== shadow_done) begin
            fail_check(r, $sformatf("rob_done %h, expected %h", rob_done, shadow_done));
        end
        for (int p = 0; p < core_cfg_pkg::PREG_NUM; p++) begin
            rd_preg = 6'(p);
            #0.1;
            check_count++;
            if (rd_data !== shadow_prf[p]) begin
                fail_check(r, $sformatf("preg %0d holds %h, expected %h", p, rd_data,
                                        shadow_prf[p]));
            end
        end
        rd_preg = '0;
    endtask

    initial begin
        int unsigned seed_draw;
        seed_draw    = $urandom(32'h31cd_8338);
        err_count    = 0;
        check_count  = 0;
        rstn         = 1'b0;
        issue_valid  = '0;
        issue_pc     = '0;
        issue_instr  = '0;
        issue_src_a  = '0;
        issue_src_b  = '0;
        issue_dest   = '0;
        issue_rob    = '0;
        retire_valid = 1'b0;
        retire_rob   = '0;
        rd_preg      = '0;
        shadow_done  = '0;
        for (int p = 0; p < core_cfg_pkg::PREG_NUM; p++) begin
            shadow_prf[p] = '0;
        end
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int t = 0; t < NROWS + 3; t++) begin
            @(posedge clk);
            #1;
            drive_row(t);
            update_shadow(t);
            check_outputs(t);
            if (t >= 3) begin
                if (row_err[t-3] == 0) begin
                    $display("row %0d %s: ok", t - 3, row_name[t-3]);
                end else begin
                    $display("row %0d %s: %0d errors", t - 3, row_name[t-3], row_err[t-3]);
                end
            end
        end
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* exec_cluster.f */
verilog/core_cfg_pkg.sv
verilog/isa_pkg.sv
verilog/issue_decode.sv
verilog/exec_lane.sv
verilog/writeback_commit.sv
verilog/exec_cluster_top.sv
sim/exec_cluster_sva.sv
sim/exec_cluster_tb.sv
